// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/core_pkg.sv
      - source/core_control.sv
      - source/inst_decoder.sv
      - source/alu.sv
      - source/register_file.sv
      - source/load_store_unit.sv
      - source/core.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/core_properties.sv
      - test/core_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic              clk,
    input  logic [31:0]       op_a,
    input  logic [31:0]       op_b,
    input  core_pkg::alu_op_t alu_op,
    input  logic [2:0]        funct3,
    output logic [31:0]       result,
    output logic              branch_taken
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [31:0] value;

    always_comb begin
        case (alu_op)
            ALU_SUB:    value = op_a - op_b;
            ALU_AND:    value = op_a & op_b;
            ALU_OR:     value = op_a | op_b;
            ALU_XOR:    value = op_a ^ op_b;
            ALU_SLT:    value = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: value = op_b;
            default:    value = op_a + op_b;
        endcase
    end

    // inputs stay stable from decode on, so sampling every cycle is enough
    always_ff @(posedge clk) begin
        result       <= value;
        branch_taken <= (funct3 == F3_BNE) ? (op_a != op_b) : (op_a == op_b);
    end

endmodule

// ==== source/core.sv ====
`timescale 1ns/10ps

module core (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_start,
    output logic [31:0] inst_addr,
    input  logic        inst_ready,
    input  logic [31:0] inst_data,
    input  logic        inst_valid,
    output logic        d_cmd_start,
    output logic        d_cmd_write,
    output logic [31:0] d_addr,
    output logic [31:0] d_wdata,
    input  logic        d_cmd_ready,
    input  logic [31:0] d_rdata,
    input  logic        d_rdata_valid,
    output logic        exit,
    output logic [31:0] gp
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [31:0] instr;
    opcode_t     opcode;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [4:0]  rd_idx;
    alu_op_t     alu_op;
    wb_sel_t     wb_sel;
    logic        use_imm;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        branch_taken;
    logic [31:0] load_data;
    logic        mem_go;
    logic        mem_done;
    logic        rf_wen;
    logic [31:0] rf_wdata;

    // second alu operand
    assign op_b = use_imm ? imm : rs2_data;

    // **********************************************************************
    // control
    // **********************************************************************
    core_control u_control (
        .clk          (clk),
        .reset        (reset),
        .inst_start   (inst_start),
        .inst_addr    (inst_addr),
        .inst_ready   (inst_ready),
        .inst_data    (inst_data),
        .inst_valid   (inst_valid),
        .opcode       (opcode),
        .alu_op_in    (alu_op),
        .wb_sel       (wb_sel),
        .imm          (imm),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .mem_done     (mem_done),
        .instr        (instr),
        .pc           (),
        .mem_go       (mem_go),
        .rf_wen       (rf_wen),
        .rf_wdata     (rf_wdata),
        .exit         (exit)
    );

    // **********************************************************************
    // datapath
    // **********************************************************************
    inst_decoder u_decoder (
        .instr   (instr),
        .opcode  (opcode),
        .rs1     (rs1_idx),
        .rs2     (rs2_idx),
        .rd      (rd_idx),
        .alu_op  (alu_op),
        .wb_sel  (wb_sel),
        .use_imm (use_imm),
        .imm     (imm)
    );

    alu u_alu (
        .clk          (clk),
        .op_a         (rs1_data),
        .op_b         (op_b),
        .alu_op       (alu_op),
        .funct3       (instr[14:12]),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    register_file u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (rf_wen),
        .rd       (rd_idx),
        .wdata    (rf_wdata),
        .gp       (gp)
    );

    load_store_unit u_lsu (
        .clk           (clk),
        .reset         (reset),
        .go            (mem_go),
        .write         (opcode == OP_STORE),
        .addr          (alu_result),
        .wdata         (rs2_data),
        .done          (mem_done),
        .load_data     (load_data),
        .d_cmd_start   (d_cmd_start),
        .d_cmd_write   (d_cmd_write),
        .d_cmd_ready   (d_cmd_ready),
        .d_addr        (d_addr),
        .d_wdata       (d_wdata),
        .d_rdata       (d_rdata),
        .d_rdata_valid (d_rdata_valid)
    );

endmodule

// ==== source/core_control.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module core_control (
    input  logic              clk,
    input  logic              reset,
    output logic              inst_start,
    output logic [31:0]       inst_addr,
    input  logic              inst_ready,
    input  logic [31:0]       inst_data,
    input  logic              inst_valid,
    input  isa_pkg::opcode_t  opcode,
    input  core_pkg::alu_op_t alu_op_in,
    input  core_pkg::wb_sel_t wb_sel,
    input  logic [31:0]       imm,
    input  logic              branch_taken,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       load_data,
    input  logic              mem_done,
    output logic [31:0]       instr,
    output logic [31:0]       pc,
    output logic              mem_go,
    output logic              rf_wen,
    output logic [31:0]       rf_wdata,
    output logic              exit
);
    import isa_pkg::*;
    import core_pkg::*;

    ctrl_state_t state;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic [31:0] next_pc;
    logic        is_mem;

    assign inst_addr = pc;
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;
    assign is_mem    = (opcode == OP_LOAD) || (opcode == OP_STORE);

    // jal always redirects, branches only when the compare hit
    always_comb begin
        if (opcode == OP_JAL || (opcode == OP_BRANCH && branch_taken))
            next_pc = pc_target;
        else
            next_pc = pc_plus4;
    end

    assign rf_wen = (state == WRITEBACK) && (wb_sel != WB_NONE);

    always_comb begin
        case (wb_sel)
            WB_MEM:  rf_wdata = load_data;
            WB_PC4:  rf_wdata = pc_plus4;
            default: rf_wdata = alu_result;
        endcase
    end

    // **********************************************************************
    // sequencer
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= `CORE_RESET_PC;
            inst_start <= 1'b0;
            mem_go     <= 1'b0;
            exit       <= 1'b0;
        end else begin
            mem_go <= 1'b0;
            case (state)
                FETCH: begin
                    inst_start <= 1'b1;
                    state      <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    // valid may come in the ready cycle
                    if (inst_ready)
                        inst_start <= 1'b0;
                    if (inst_valid)
                        state <= DECODE;
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    if (opcode == OP_SYSTEM) begin
                        exit  <= 1'b1;
                        state <= HALT;
                    end else if (is_mem) begin
                        mem_go <= 1'b1;
                        state  <= MEMORY;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (mem_done)
                        state <= WRITEBACK;
                end
                WRITEBACK: begin
                    pc    <= next_pc;
                    state <= FETCH;
                end
                HALT: state <= HALT;
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && inst_valid)
            instr <= inst_data;
    end

endmodule

// ==== source/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural register count
`define CORE_REG_COUNT 32

// register brought out on the gp port
`define CORE_GP_REG 3

`endif

// ==== source/core_pkg.sv ====
package core_pkg;

    // instruction sequencer
    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_NONE
    } wb_sel_t;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
    input  logic [31:0]       instr,
    output isa_pkg::opcode_t  opcode,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output core_pkg::alu_op_t alu_op,
    output core_pkg::wb_sel_t wb_sel,
    output logic              use_imm,
    output logic [31:0]       imm
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [6:0]  raw_op;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic        known;

    assign raw_op = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        known   = 1'b1;
        opcode  = opcode_t'(raw_op);
        alu_op  = ALU_ADD;
        wb_sel  = WB_NONE;
        use_imm = 1'b0;
        imm     = imm_i;
        case (raw_op)
            OP_LUI: begin
                alu_op  = ALU_PASS_B;
                wb_sel  = WB_ALU;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            OP_IMM: begin
                known   = (funct3 == F3_ADD_SUB);
                wb_sel  = WB_ALU;
                use_imm = 1'b1;
            end
            OP_REG: begin
                wb_sel = WB_ALU;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD_SUB}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
                    default:               known  = 1'b0;
                endcase
            end
            OP_LOAD: begin
                known   = (funct3 == F3_WORD);
                wb_sel  = WB_MEM;
                use_imm = 1'b1;
            end
            OP_STORE: begin
                known   = (funct3 == F3_WORD);
                use_imm = 1'b1;
                imm     = imm_s;
            end
            OP_BRANCH: begin
                known  = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                alu_op = ALU_SUB;
                imm    = imm_b;
            end
            OP_JAL: begin
                wb_sel = WB_PC4;
                imm    = imm_j;
            end
            // only ecall, everything else in system space is ignored
            OP_SYSTEM: known = (instr[31:7] == 25'd0);
            default:   known = 1'b0;
        endcase
        // unknown encodings retire as an addi that writes nothing
        if (!known) begin
            opcode = OP_IMM;
            wb_sel = WB_NONE;
        end
    end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    // **********************************************************************
    // major opcodes of the supported subset
    // **********************************************************************
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 for OP_IMM / OP_REG
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // lw / sw width
    localparam logic [2:0] F3_WORD    = 3'b010;

    // funct7, ALT selects sub
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

endpackage

// ==== source/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic        go,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        done,
    output logic [31:0] load_data,
    output logic        d_cmd_start,
    output logic        d_cmd_write,
    input  logic        d_cmd_ready,
    output logic [31:0] d_addr,
    output logic [31:0] d_wdata,
    input  logic [31:0] d_rdata,
    input  logic        d_rdata_valid
);
    typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_RESP} lsu_state_t;

    lsu_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= LSU_IDLE;
            d_cmd_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (go) begin
                        d_cmd_start <= 1'b1;
                        state       <= LSU_REQ;
                    end
                end
                LSU_REQ: begin
                    if (d_cmd_ready) begin
                        d_cmd_start <= 1'b0;
                        // writes end at ready, reads may see data here too
                        if (d_cmd_write || d_rdata_valid) begin
                            done  <= 1'b1;
                            state <= LSU_IDLE;
                        end else begin
                            state <= LSU_RESP;
                        end
                    end
                end
                LSU_RESP: begin
                    if (d_rdata_valid) begin
                        done  <= 1'b1;
                        state <= LSU_IDLE;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    // request fields held until ready
    always_ff @(posedge clk) begin
        if (state == LSU_IDLE && go) begin
            d_cmd_write <= write;
            d_addr      <= addr;
            d_wdata     <= wdata;
        end
        if (d_rdata_valid)
            load_data <= d_rdata;
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wen,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    output logic [31:0] gp
);
    logic [31:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++)
                regs[i] <= 32'd0;
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign gp       = regs[`CORE_GP_REG];

endmodule

// ==== test/core_properties.sv ====
`timescale 1ns/10ps

module core_properties (
    input logic        clk,
    input logic        reset,
    input logic        inst_start,
    input logic [31:0] inst_addr,
    input logic        inst_ready,
    input logic        inst_valid,
    input logic        d_cmd_start,
    input logic        d_cmd_write,
    input logic [31:0] d_addr,
    input logic [31:0] d_wdata,
    input logic        d_cmd_ready,
    input logic        d_rdata_valid,
    input logic        exit
);
    logic fetch_open;
    logic read_open;
    int   failures = 0;

    // open from the ready cycle until the data comes back
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_open <= 1'b0;
            read_open  <= 1'b0;
        end else begin
            if (inst_start && inst_ready && !inst_valid)
                fetch_open <= 1'b1;
            else if (inst_valid)
                fetch_open <= 1'b0;
            if (d_cmd_start && d_cmd_ready && !d_cmd_write && !d_rdata_valid)
                read_open <= 1'b1;
            else if (d_rdata_valid)
                read_open <= 1'b0;
        end
    end

    // **********************************************************************
    // instruction port
    // **********************************************************************
    inst_held: assert property (@(posedge clk) disable iff (reset)
        inst_start && !inst_ready |=> inst_start && $stable(inst_addr))
        else begin
            $error("inst_start or inst_addr changed before inst_ready");
            failures++;
        end

    inst_drop: assert property (@(posedge clk) disable iff (reset)
        inst_start && inst_ready |=> !inst_start)
        else begin
            $error("inst_start stayed high after inst_ready");
            failures++;
        end

    inst_single: assert property (@(posedge clk) disable iff (reset)
        fetch_open |-> !inst_start)
        else begin
            $error("second fetch issued while one is outstanding");
            failures++;
        end

    // **********************************************************************
    // data port
    // **********************************************************************
    data_held: assert property (@(posedge clk) disable iff (reset)
        d_cmd_start && !d_cmd_ready |=> d_cmd_start && $stable(d_addr)
            && $stable(d_wdata) && $stable(d_cmd_write))
        else begin
            $error("data request changed before d_cmd_ready");
            failures++;
        end

    data_single: assert property (@(posedge clk) disable iff (reset)
        read_open |-> !d_cmd_start)
        else begin
            $error("second data request issued while a read is outstanding");
            failures++;
        end

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        exit |=> exit && !inst_start && !d_cmd_start)
        else begin
            $error("core left halt or started a request after exit");
            failures++;
        end

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module core_tb;
    import isa_pkg::*;

    localparam int PROG_LEN       = 48;
    localparam int IMEM_WORDS     = 64;
    localparam int DMEM_WORDS     = 64;
    localparam int TIMEOUT_CYCLES = 16 + 49 * 16;

    typedef enum int {
        K_LUI, K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR,
        K_SLT, K_LW, K_SW, K_BEQ, K_BNE, K_JAL
    } kind_t;

    logic        clk;
    logic        reset;
    logic        inst_start;
    logic [31:0] inst_addr;
    logic        inst_ready;
    logic [31:0] inst_data;
    logic        inst_valid;
    logic        d_cmd_start;
    logic        d_cmd_write;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        d_cmd_ready;
    logic [31:0] d_rdata;
    logic        d_rdata_valid;
    logic        exit;
    logic [31:0] gp;

    integer      seed = 32'h8708_5af3;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    kind_t       prog_kind [PROG_LEN];
    logic [4:0]  prog_rd   [PROG_LEN];
    logic [4:0]  prog_rs1  [PROG_LEN];
    logic [4:0]  prog_rs2  [PROG_LEN];
    logic [31:0] prog_imm  [PROG_LEN];
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_fetch [$];
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    logic [31:0] exp_gp;

    core dut (.*);

    bind core core_properties u_properties (.*);

    function automatic int unsigned rand_below(input int unsigned n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [31:0] assemble(input int i);
        logic [31:0] m;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        m   = prog_imm[i];
        rd  = prog_rd[i];
        rs1 = prog_rs1[i];
        rs2 = prog_rs2[i];
        case (prog_kind[i])
            K_LUI:  return {m[31:12], rd, OP_LUI};
            K_ADDI: return {m[11:0], rs1, F3_ADD_SUB, rd, OP_IMM};
            K_ADD:  return {F7_BASE, rs2, rs1, F3_ADD_SUB, rd, OP_REG};
            K_SUB:  return {F7_ALT, rs2, rs1, F3_ADD_SUB, rd, OP_REG};
            K_AND:  return {F7_BASE, rs2, rs1, F3_AND, rd, OP_REG};
            K_OR:   return {F7_BASE, rs2, rs1, F3_OR, rd, OP_REG};
            K_XOR:  return {F7_BASE, rs2, rs1, F3_XOR, rd, OP_REG};
            K_SLT:  return {F7_BASE, rs2, rs1, F3_SLT, rd, OP_REG};
            K_LW:   return {m[11:0], rs1, F3_WORD, rd, OP_LOAD};
            K_SW:   return {m[11:5], rs2, rs1, F3_WORD, m[4:0], OP_STORE};
            K_BEQ:  return {m[12], m[10:5], rs2, rs1, F3_BEQ, m[4:1], m[11], OP_BRANCH};
            K_BNE:  return {m[12], m[10:5], rs2, rs1, F3_BNE, m[4:1], m[11], OP_BRANCH};
            default: return {m[20], m[10:1], m[11], m[19:12], rd, OP_JAL};
        endcase
    endfunction

    // **********************************************************************
    // random program with ecall fill behind it and random data words
    // **********************************************************************
    task automatic build_program();
        logic [31:0] r;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog_kind[i] = kind_t'(rand_below(13));
            prog_rd[i]   = 5'(rand_below(8));
            prog_rs1[i]  = 5'(rand_below(8));
            prog_rs2[i]  = 5'(rand_below(8));
            r = $random(seed);
            case (prog_kind[i])
                K_LUI:  prog_imm[i] = r & 32'hffff_f000;
                K_ADDI: prog_imm[i] = {{20{r[11]}}, r[11:0]};
                K_LW, K_SW: begin
                    // x0 base keeps the access inside the window
                    prog_rs1[i] = 5'd0;
                    prog_imm[i] = 32'(rand_below(DMEM_WORDS) * 4);
                end
                default: prog_imm[i] = 32'(4 * (2 + rand_below(3)));
            endcase
            imem[i] = assemble(i);
        end
        for (int i = PROG_LEN; i < IMEM_WORDS; i++)
            imem[i] = {25'd0, OP_SYSTEM};
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = $random(seed);
    endtask

    // isa model stepped once before the run
    task automatic run_model();
        logic [31:0] regs [`CORE_REG_COUNT];
        logic [31:0] mem  [DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        writes;
        int          idx;
        for (int i = 0; i < `CORE_REG_COUNT; i++)
            regs[i] = 32'd0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = dmem[i];
        pc  = `CORE_RESET_PC;
        idx = pc[31:2];
        while (idx < PROG_LEN) begin
            exp_fetch.push_back(pc);
            a       = regs[prog_rs1[idx]];
            b       = regs[prog_rs2[idx]];
            res     = a + prog_imm[idx];
            writes  = 1'b1;
            next_pc = pc + 32'd4;
            case (prog_kind[idx])
                K_LUI:  res = prog_imm[idx];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_LW:   res = mem[res[7:2]];
                K_SW: begin
                    writes = 1'b0;
                    mem[res[7:2]] = b;
                    exp_store_addr.push_back(res);
                    exp_store_data.push_back(b);
                end
                K_BEQ, K_BNE: begin
                    writes = 1'b0;
                    if ((a == b) == (prog_kind[idx] == K_BEQ))
                        next_pc = pc + prog_imm[idx];
                end
                K_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + prog_imm[idx];
                end
                default: ;
            endcase
            if (writes && prog_rd[idx] != 5'd0)
                regs[prog_rd[idx]] = res;
            pc  = next_pc;
            idx = pc[31:2];
        end
        // the ecall fetch
        exp_fetch.push_back(pc);
        exp_gp = regs[`CORE_GP_REG];
    endtask

    task automatic check_fetch(input logic [31:0] addr);
        logic [31:0] exp;
        checks++;
        assert (exp_fetch.size() > 0) else begin
            $display("fetch at %h after the program should have ended", addr);
            errors++;
        end
        if (exp_fetch.size() > 0) begin
            exp = exp_fetch.pop_front();
            assert (addr == exp) else begin
                $display("Error: inst_addr is %h, expected %h", addr, exp);
                errors++;
            end
        end
    endtask

    task automatic match_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        checks++;
        assert (exp_store_addr.size() > 0) else begin
            $display("unexpected extra store to %h", addr);
            errors++;
        end
        if (exp_store_addr.size() > 0) begin
            exp_addr = exp_store_addr.pop_front();
            exp_data = exp_store_data.pop_front();
            assert (addr == exp_addr) else begin
                $display("Error: d_addr is %h, expected %h", addr, exp_addr);
                errors++;
            end
            assert (data == exp_data) else begin
                $display("Error: d_wdata is %h, expected %h", data, exp_data);
                errors++;
            end
        end
    endtask

    // **********************************************************************
    // memory models with 0 to 3 cycles on ready and on valid
    // **********************************************************************
    initial begin : inst_memory
        int unsigned lag;
        inst_ready = 1'b0;
        inst_valid = 1'b0;
        inst_data  = 32'd0;
        forever begin
            @(negedge clk);
            if (inst_start === 1'b1) begin
                check_fetch(inst_addr);
                repeat (rand_below(4)) @(negedge clk);
                inst_ready = 1'b1;
                inst_data  = imem[inst_addr[7:2]];
                lag        = rand_below(4);
                inst_valid = (lag == 0);
                @(negedge clk);
                inst_ready = 1'b0;
                if (lag != 0) begin
                    repeat (lag - 1) @(negedge clk);
                    inst_valid = 1'b1;
                    @(negedge clk);
                end
                inst_valid = 1'b0;
            end
        end
    end

    initial begin : data_memory
        int unsigned lag;
        d_cmd_ready   = 1'b0;
        d_rdata_valid = 1'b0;
        d_rdata       = 32'd0;
        forever begin
            @(negedge clk);
            if (d_cmd_start === 1'b1) begin
                checks++;
                assert (d_addr < 32'(DMEM_WORDS * 4) && d_addr[1:0] == 2'b00) else begin
                    $display("data access at %h falls outside the data window", d_addr);
                    errors++;
                end
                repeat (rand_below(4)) @(negedge clk);
                d_cmd_ready = 1'b1;
                lag = 0;
                if (d_cmd_write) begin
                    match_store(d_addr, d_wdata);
                    dmem[d_addr[7:2]] = d_wdata;
                end else begin
                    lag           = rand_below(4);
                    d_rdata       = dmem[d_addr[7:2]];
                    d_rdata_valid = (lag == 0);
                end
                @(negedge clk);
                d_cmd_ready = 1'b0;
                if (lag != 0) begin
                    repeat (lag - 1) @(negedge clk);
                    d_rdata_valid = 1'b1;
                    @(negedge clk);
                end
                d_rdata_valid = 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES && exit !== 1'b1) begin
            errors++;
            $display("timeout before exit");
            $display("%0d checks, %0d errors", checks, errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin : main
        reset = 1'b1;
        build_program();
        run_model();
        repeat (16) @(negedge clk);
        checks++;
        assert (inst_start === 1'b0 && d_cmd_start === 1'b0 && exit === 1'b0) else begin
            $display("a request or exit is active during reset");
            errors++;
        end
        reset = 1'b0;
        while (exit !== 1'b1)
            @(negedge clk);
        checks++;
        assert (gp == exp_gp) else begin
            $display("Error: gp is %h, expected %h", gp, exp_gp);
            errors++;
        end
        assert (exp_fetch.size() == 0) else begin
            $display("core exited with %0d fetches still expected", exp_fetch.size());
            errors++;
        end
        assert (exp_store_addr.size() == 0) else begin
            $display("core exited with %0d stores still expected", exp_store_addr.size());
            errors++;
        end
        // halted core stays quiet
        repeat (20) begin
            @(negedge clk);
            assert (!inst_start && !d_cmd_start && exit) else begin
                $display("a request started or exit dropped after the halt");
                errors++;
            end
        end
        // handshake property failures from the bound checker
        errors += dut.u_properties.failures;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/core_control.sv
source/inst_decoder.sv
source/alu.sv
source/register_file.sv
source/load_store_unit.sv
source/core.sv
test/core_properties.sv
test/core_tb.sv
